// File: Makefile
TOP := drp_bridge_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -j 0 --top-module $(TOP) -f drp_bridge.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir

// File: drp_bridge.f
hdl/drp_bridge_pkg.sv
hdl/axil_channel_reg.sv
hdl/drp_txn_sequencer.sv
hdl/drp_port_mux.sv
hdl/drp_bridge.sv
verification/drp_port_model.sv
verification/drp_bridge_tb.sv

// File: hdl/axil_channel_reg.sv
`timescale 1ns/100ps

module axil_channel_reg #(
  parameter type payload_t = logic
) (
  input  logic     AXI_aclk,
  input  logic     AXI_sreset,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     pop
);

  logic     full;
  logic     live;   // Goes high one cycle after reset
  payload_t held;

  assign in_ready  = live && !full;
  assign out_valid = full;
  assign out_data  = held;

  always_ff @(posedge AXI_aclk or posedge AXI_sreset) begin
    if (AXI_sreset) begin
      live <= 1'b0;
      full <= 1'b0;
    end else begin
      live <= 1'b1;
      if (in_valid && in_ready) begin
        full <= 1'b1;
      end else if (pop) begin
        full <= 1'b0;
      end
    end
  end

  // Capture only while empty
  always_ff @(posedge AXI_aclk) begin
    if (in_valid && in_ready) begin
      held <= in_data;
    end
  end

endmodule

// File: hdl/drp_bridge.sv
`timescale 1ns/100ps

module drp_bridge #(
  parameter int DRP_COUNT = 4
) (
  input  logic                                      AXI_aclk,
  input  logic                                      AXI_sreset,

  input  logic [drp_bridge_pkg::AXI_ADDR_W-1:0]     s_axi_awaddr,
  input  logic [2:0]                                s_axi_awprot,   // Ignored
  input  logic                                      s_axi_awvalid,
  output logic                                      s_axi_awready,

  input  logic [drp_bridge_pkg::AXI_DATA_W-1:0]     s_axi_wdata,
  input  logic [drp_bridge_pkg::AXI_DATA_W/8-1:0]   s_axi_wstrb,    // Full word always written
  input  logic                                      s_axi_wvalid,
  output logic                                      s_axi_wready,

  output logic [1:0]                                s_axi_bresp,
  output logic                                      s_axi_bvalid,
  input  logic                                      s_axi_bready,

  input  logic [drp_bridge_pkg::AXI_ADDR_W-1:0]     s_axi_araddr,
  input  logic [2:0]                                s_axi_arprot,   // Ignored
  input  logic                                      s_axi_arvalid,
  output logic                                      s_axi_arready,

  output logic [drp_bridge_pkg::AXI_DATA_W-1:0]     s_axi_rdata,
  output logic [1:0]                                s_axi_rresp,
  output logic                                      s_axi_rvalid,
  input  logic                                      s_axi_rready,

  output drp_bridge_pkg::drp_req_t                  drp_req [DRP_COUNT],
  input  drp_bridge_pkg::drp_rsp_t                  drp_rsp [DRP_COUNT]
);

  import drp_bridge_pkg::*;

  localparam int SEL_W = sel_width(DRP_COUNT);

  logic                  aw_valid, aw_pop;
  logic                  w_valid, w_pop;
  logic                  ar_valid, ar_pop;
  axil_addr_t            aw_data;
  axil_wdata_t           w_data;
  axil_addr_t            ar_data;
  logic                  req_valid, req_we;
  logic [SEL_W-1:0]      req_sel;
  logic [DRP_ADDR_W-1:0] req_addr;
  logic [DRP_DATA_W-1:0] req_di;
  logic                  done;
  logic [DRP_DATA_W-1:0] drp_data;

  axil_channel_reg #(.payload_t(axil_addr_t)) aw_reg_i (
    .AXI_aclk, .AXI_sreset,
    .in_valid(s_axi_awvalid), .in_ready(s_axi_awready), .in_data(axil_addr_t'(s_axi_awaddr)),
    .out_valid(aw_valid), .out_data(aw_data), .pop(aw_pop)
  );

  axil_channel_reg #(.payload_t(axil_wdata_t)) w_reg_i (
    .AXI_aclk, .AXI_sreset,
    .in_valid(s_axi_wvalid), .in_ready(s_axi_wready), .in_data(axil_wdata_t'(s_axi_wdata)),
    .out_valid(w_valid), .out_data(w_data), .pop(w_pop)
  );

  axil_channel_reg #(.payload_t(axil_addr_t)) ar_reg_i (
    .AXI_aclk, .AXI_sreset,
    .in_valid(s_axi_arvalid), .in_ready(s_axi_arready), .in_data(axil_addr_t'(s_axi_araddr)),
    .out_valid(ar_valid), .out_data(ar_data), .pop(ar_pop)
  );

  drp_txn_sequencer #(.DRP_COUNT(DRP_COUNT)) seq_i (
    .AXI_aclk, .AXI_sreset,
    .aw_valid, .aw_data, .aw_pop, .w_valid, .w_data, .w_pop, .ar_valid, .ar_data, .ar_pop,
    .bvalid(s_axi_bvalid), .bresp(s_axi_bresp), .bready(s_axi_bready),
    .rvalid(s_axi_rvalid), .rresp(s_axi_rresp), .rdata(s_axi_rdata), .rready(s_axi_rready),
    .req_valid, .req_we, .req_sel, .req_addr, .req_di, .done, .drp_data
  );

  drp_port_mux #(.DRP_COUNT(DRP_COUNT)) mux_i (
    .req_valid, .req_we, .req_sel, .req_addr, .req_di,
    .drp_req, .drp_rsp, .done, .drp_data
  );

endmodule

// File: hdl/drp_bridge_pkg.sv
package drp_bridge_pkg;

  localparam int AXI_ADDR_W    = 32;
  localparam int AXI_DATA_W    = 32;
  localparam int DRP_ADDR_W    = 9;
  localparam int DRP_DATA_W    = 16;
  localparam int MAX_DRP_COUNT = 32;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_DECERR = 2'b11
  } axil_resp_t;

  // AW and AR payload
  typedef struct packed {
    logic [AXI_ADDR_W-1:0] addr;
  } axil_addr_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
  } axil_wdata_t;

  // Bridge to port
  typedef struct packed {
    logic                  en;
    logic                  we;
    logic [DRP_ADDR_W-1:0] addr;
    logic [DRP_DATA_W-1:0] di;
  } drp_req_t;

  // Port to bridge
  typedef struct packed {
    logic                  rdy;
    logic [DRP_DATA_W-1:0] dout;
  } drp_rsp_t;

  // Port select width of at least one bit
  function automatic int sel_width(input int count);
    int w;
    w = 1;
    while ((1 << w) < count) begin
      w++;
    end
    return w;
  endfunction

endpackage

// File: hdl/drp_port_mux.sv
`timescale 1ns/100ps

module drp_port_mux #(
  parameter int DRP_COUNT = 4
) (
  input  logic                                            req_valid,
  input  logic                                            req_we,
  input  logic [drp_bridge_pkg::sel_width(DRP_COUNT)-1:0] req_sel,
  input  logic [drp_bridge_pkg::DRP_ADDR_W-1:0]           req_addr,
  input  logic [drp_bridge_pkg::DRP_DATA_W-1:0]           req_di,

  output drp_bridge_pkg::drp_req_t                        drp_req [DRP_COUNT],
  input  drp_bridge_pkg::drp_rsp_t                        drp_rsp [DRP_COUNT],

  output logic                                            done,
  output logic [drp_bridge_pkg::DRP_DATA_W-1:0]           drp_data
);

  import drp_bridge_pkg::*;

  // One-hot strobes, shared address and data
  for (genvar i = 0; i < DRP_COUNT; i++) begin : g_port
    logic hit;

    assign hit = req_valid && (int'(req_sel) == i);

    assign drp_req[i] = '{
      en:   hit,
      we:   hit && req_we,
      addr: req_addr,
      di:   req_di
    };
  end

  // Selected port back to the sequencer
  always_comb begin
    done     = 1'b0;
    drp_data = '0;
    for (int i = 0; i < DRP_COUNT; i++) begin
      if (int'(req_sel) == i) begin
        done     = drp_rsp[i].rdy;
        drp_data = drp_rsp[i].dout;
      end
    end
  end

endmodule

// File: hdl/drp_txn_sequencer.sv
`timescale 1ns/100ps

module drp_txn_sequencer #(
  parameter int DRP_COUNT = 4
) (
  input  logic                                           AXI_aclk,
  input  logic                                           AXI_sreset,

  input  logic                                           aw_valid,
  input  drp_bridge_pkg::axil_addr_t                     aw_data,
  output logic                                           aw_pop,
  input  logic                                           w_valid,
  input  drp_bridge_pkg::axil_wdata_t                    w_data,
  output logic                                           w_pop,
  input  logic                                           ar_valid,
  input  drp_bridge_pkg::axil_addr_t                     ar_data,
  output logic                                           ar_pop,

  output logic                                           bvalid,
  output drp_bridge_pkg::axil_resp_t                     bresp,
  input  logic                                           bready,
  output logic                                           rvalid,
  output drp_bridge_pkg::axil_resp_t                     rresp,
  output logic [drp_bridge_pkg::AXI_DATA_W-1:0]          rdata,
  input  logic                                           rready,

  output logic                                           req_valid,
  output logic                                           req_we,
  output logic [drp_bridge_pkg::sel_width(DRP_COUNT)-1:0] req_sel,
  output logic [drp_bridge_pkg::DRP_ADDR_W-1:0]          req_addr,
  output logic [drp_bridge_pkg::DRP_DATA_W-1:0]          req_di,
  input  logic                                           done,
  input  logic [drp_bridge_pkg::DRP_DATA_W-1:0]          drp_data
);

  import drp_bridge_pkg::*;

  localparam int SEL_W   = sel_width(DRP_COUNT);
  localparam int SEL_LSB = DRP_ADDR_W + 2;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DRP_WAIT,
    ST_WR_RESP,
    ST_RD_RESP
  } state_t;

  state_t                 state;
  logic                   err_q;
  logic                   wr_start;
  logic                   rd_start;
  logic                   start;
  logic [AXI_ADDR_W-1:0]  cur_addr;
  logic [SEL_W-1:0]       cur_sel;
  logic [DRP_ADDR_W-1:0]  cur_reg;
  logic                   sel_ok;
  logic                   finish;

  // Writes need both AW and W, and beat a pending read
  assign wr_start = aw_valid && w_valid;
  assign rd_start = ar_valid && !wr_start;
  assign start    = (state == ST_IDLE) && (wr_start || rd_start);

  assign cur_addr = wr_start ? aw_data.addr : ar_data.addr;
  assign cur_reg  = cur_addr[2 +: DRP_ADDR_W];
  assign cur_sel  = cur_addr[SEL_LSB +: SEL_W];
  assign sel_ok   = int'(cur_sel) < DRP_COUNT;

  assign aw_pop = start && wr_start;
  assign w_pop  = start && wr_start;
  assign ar_pop = start && rd_start;

  // Errored requests leave the wait state without a port access
  assign finish = (state == ST_DRP_WAIT) && (err_q || done);

  always_ff @(posedge AXI_aclk or posedge AXI_sreset) begin
    if (AXI_sreset) begin
      state     <= ST_IDLE;
      req_valid <= 1'b0;
      req_we    <= 1'b0;
      err_q     <= 1'b0;
      bvalid    <= 1'b0;
      rvalid    <= 1'b0;
    end else begin
      req_valid <= 1'b0;   // One-cycle pulse
      case (state)
        ST_IDLE: begin
          if (start) begin
            req_we    <= wr_start;
            req_valid <= sel_ok;
            err_q     <= !sel_ok;
            state     <= ST_DRP_WAIT;
          end
        end
        ST_DRP_WAIT: begin
          if (finish) begin
            if (req_we) begin
              bvalid <= 1'b1;
              state  <= ST_WR_RESP;
            end else begin
              rvalid <= 1'b1;
              state  <= ST_RD_RESP;
            end
          end
        end
        ST_WR_RESP: begin
          if (bready) begin
            bvalid <= 1'b0;
            state  <= ST_IDLE;
          end
        end
        ST_RD_RESP: begin
          if (rready) begin
            rvalid <= 1'b0;
            state  <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Command fields and response payload
  always_ff @(posedge AXI_aclk) begin
    if (start) begin
      req_sel  <= cur_sel;
      req_addr <= cur_reg;
      req_di   <= w_data.data[DRP_DATA_W-1:0];   // Upper bits dropped
    end
    if (finish && req_we) begin
      bresp <= err_q ? RESP_DECERR : RESP_OKAY;
    end
    if (finish && !req_we) begin
      rresp <= err_q ? RESP_DECERR : RESP_OKAY;
      if (err_q) begin
        rdata <= '0;
      end else begin
        rdata <= {{(AXI_DATA_W - DRP_DATA_W){1'b0}}, drp_data};
      end
    end
  end

endmodule

// File: verification/drp_bridge_tb.sv
`timescale 1ns/100ps

module drp_bridge_tb;

  import drp_bridge_pkg::*;

  localparam int PORTS     = 3;
  localparam int NUM_TESTS = 5;

  logic                  AXI_aclk;
  logic                  AXI_sreset;
  logic [AXI_ADDR_W-1:0] awaddr, araddr;
  logic [AXI_DATA_W-1:0] wdata, rdata;
  logic                  awvalid, awready, wvalid, wready, bvalid, bready;
  logic                  arvalid, arready, rvalid, rready;
  logic [1:0]            bresp, rresp;
  drp_req_t              drp_req [PORTS];
  drp_rsp_t              drp_rsp [PORTS];
  int                    value_errs;
  int                    other_errs;
  int                    en_total;

  drp_bridge #(.DRP_COUNT(PORTS)) dut_i (
    .AXI_aclk, .AXI_sreset,
    .s_axi_awaddr(awaddr), .s_axi_awprot(3'b000), .s_axi_awvalid(awvalid),
    .s_axi_awready(awready),
    .s_axi_wdata(wdata), .s_axi_wstrb(4'hf), .s_axi_wvalid(wvalid), .s_axi_wready(wready),
    .s_axi_bresp(bresp), .s_axi_bvalid(bvalid), .s_axi_bready(bready),
    .s_axi_araddr(araddr), .s_axi_arprot(3'b000), .s_axi_arvalid(arvalid),
    .s_axi_arready(arready),
    .s_axi_rdata(rdata), .s_axi_rresp(rresp), .s_axi_rvalid(rvalid), .s_axi_rready(rready),
    .drp_req, .drp_rsp
  );

  for (genvar p = 0; p < PORTS; p++) begin : g_model
    drp_port_model #(.IDX(p)) port_i (
      .AXI_aclk, .AXI_sreset, .req(drp_req[p]), .rsp(drp_rsp[p])
    );
  end

  initial begin
    AXI_aclk = 1'b0;
    forever #10 AXI_aclk = ~AXI_aclk;
  end

  // Port strobes counted mid-cycle
  always @(negedge AXI_aclk) begin
    for (int i = 0; i < PORTS; i++) begin
      if (!AXI_sreset && drp_req[i].en) en_total++;
    end
  end

  initial begin
    repeat (NUM_TESTS * 200) @(posedge AXI_aclk);
    $display("Watchdog expired, the DUT stopped responding");
    $display(">>> FAIL");
    $finish;
  end

  function automatic logic [AXI_ADDR_W-1:0] make_addr(input int port, input int regn);
    return (AXI_ADDR_W'(port) << (DRP_ADDR_W + 2)) | (AXI_ADDR_W'(regn) << 2);
  endfunction

  // Power-up content of a model register
  function automatic logic [AXI_DATA_W-1:0] init_value(input int port, input int regn);
    return {16'h0, port[3:0], 3'b000, regn[8:0]};
  endfunction

  task automatic check_resp(input string name, input axil_resp_t exp, input axil_resp_t act);
    if (exp !== act) begin
      $display("error %s: expected resp %0d, actual %0d", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_data(input string name, input logic [AXI_DATA_W-1:0] exp,
                            input logic [AXI_DATA_W-1:0] act);
    if (exp !== act) begin
      $display("error %s: expected data %h, actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  // Request channels open one cycle after reset
  task automatic check_ready(input string name, input logic exp);
    if (awready !== exp || wready !== exp || arready !== exp) begin
      $display("error %s: expected ready %b, actual aw %b w %b ar %b", name, exp, awready,
               wready, arready);
      value_errs++;
    end
  endtask

  task automatic axil_write(input string name, input logic [AXI_ADDR_W-1:0] addr,
                            input logic [AXI_DATA_W-1:0] data, input int w_delay,
                            input int b_delay, output axil_resp_t resp);
    bit aw_done, w_done, hs_aw, hs_w;
    int cyc;
    aw_done = 0;
    w_done  = 0;
    cyc     = 0;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = (w_delay == 0);
    while (!(aw_done && w_done)) begin
      hs_aw = awvalid && awready;   // Sampled where stable
      hs_w  = wvalid && wready;
      @(posedge AXI_aclk);
      #2;
      cyc++;
      if (hs_aw) begin
        awvalid = 1'b0;
        aw_done = 1;
      end
      if (hs_w) begin
        wvalid = 1'b0;
        w_done = 1;
      end
      if (!w_done && cyc >= w_delay) wvalid = 1'b1;
    end
    while (!bvalid) begin
      @(posedge AXI_aclk);
      #2;
    end
    resp = axil_resp_t'(bresp);
    repeat (b_delay) begin
      @(posedge AXI_aclk);
      #2;
      if (!bvalid || bresp !== resp) begin
        $display("%s: write response dropped or changed while bready was low", name);
        other_errs++;
      end
    end
    bready = 1'b1;
    @(posedge AXI_aclk);
    #2;
    bready = 1'b0;
  endtask

  task automatic axil_read(input string name, input logic [AXI_ADDR_W-1:0] addr,
                           input int r_delay, output axil_resp_t resp,
                           output logic [AXI_DATA_W-1:0] data);
    bit hs;
    araddr  = addr;
    arvalid = 1'b1;
    hs      = 0;
    while (!hs) begin
      hs = arready;
      @(posedge AXI_aclk);
      #2;
    end
    arvalid = 1'b0;
    while (!rvalid) begin
      @(posedge AXI_aclk);
      #2;
    end
    resp = axil_resp_t'(rresp);
    data = rdata;
    repeat (r_delay) begin
      @(posedge AXI_aclk);
      #2;
      if (!rvalid || rresp !== resp || rdata !== data) begin
        $display("%s: read response dropped or changed while rready was low", name);
        other_errs++;
      end
    end
    rready = 1'b1;
    @(posedge AXI_aclk);
    #2;
    rready = 1'b0;
  endtask

  task automatic test_port_access();
    axil_resp_t            resp;
    logic [AXI_DATA_W-1:0] data;
    for (int p = 0; p < PORTS; p++) begin
      axil_read("port_read_init", make_addr(p, 10 + p), 0, resp, data);
      check_resp("port_read_init", RESP_OKAY, resp);
      check_data("port_read_init", init_value(p, 10 + p), data);
      axil_write("port_write", make_addr(p, 10 + p), 32'hdead_a000 + p * 32'h111, 0, 0, resp);
      check_resp("port_write", RESP_OKAY, resp);
      axil_read("port_readback", make_addr(p, 10 + p), 0, resp, data);
      check_resp("port_readback", RESP_OKAY, resp);
      check_data("port_readback", 32'h0000_a000 + p * 32'h111, data);
    end
  endtask

  task automatic test_decerr();
    axil_resp_t            resp;
    logic [AXI_DATA_W-1:0] data;
    int                    en_before;
    en_before = en_total;
    axil_write("decerr_write", make_addr(3, 5), 32'h0000_5555, 0, 0, resp);
    check_resp("decerr_write", RESP_DECERR, resp);
    axil_read("decerr_read", make_addr(3, 5), 0, resp, data);
    check_resp("decerr_read", RESP_DECERR, resp);
    check_data("decerr_read", '0, data);
    if (en_total != en_before) begin
      $display("decerr: a port was enabled by an out-of-range request");
      other_errs++;
    end
    axil_read("decerr_port0", make_addr(0, 5), 0, resp, data);
    check_resp("decerr_port0", RESP_OKAY, resp);
    check_data("decerr_port0", init_value(0, 5), data);
  endtask

  task automatic test_write_priority();
    axil_resp_t            wresp, rresp_v;
    logic [AXI_DATA_W-1:0] data;
    fork
      axil_write("priority_write", make_addr(1, 40), 32'h0000_7e57, 0, 0, wresp);
      axil_read("priority_read", make_addr(1, 40), 0, rresp_v, data);
    join
    check_resp("priority_write", RESP_OKAY, wresp);
    check_resp("priority_read", RESP_OKAY, rresp_v);
    check_data("priority_read", 32'h0000_7e57, data);
  endtask

  task automatic test_backpressure();
    axil_resp_t            resp;
    logic [AXI_DATA_W-1:0] data;
    axil_write("hold_write", make_addr(2, 77), 32'h0000_b0b0, 0, 10, resp);
    check_resp("hold_write", RESP_OKAY, resp);
    repeat (3) begin
      if (bvalid) begin
        $display("hold_write: a second write response appeared");
        other_errs++;
      end
      @(posedge AXI_aclk);
      #2;
    end
    axil_read("hold_read", make_addr(2, 77), 10, resp, data);
    check_resp("hold_read", RESP_OKAY, resp);
    check_data("hold_read", 32'h0000_b0b0, data);
    repeat (3) begin
      if (rvalid) begin
        $display("hold_read: a second read response appeared");
        other_errs++;
      end
      @(posedge AXI_aclk);
      #2;
    end
  endtask

  task automatic test_split_write();
    axil_resp_t            resp;
    logic [AXI_DATA_W-1:0] data;
    int                    en_before;
    en_before = en_total;
    axil_write("split_write", make_addr(0, 300), 32'h0000_c3c3, 6, 0, resp);
    check_resp("split_write", RESP_OKAY, resp);
    if (en_total != en_before + 1) begin
      $display("split_write: expected one port access, saw %0d", en_total - en_before);
      other_errs++;
    end
    axil_read("split_readback", make_addr(0, 300), 0, resp, data);
    check_resp("split_readback", RESP_OKAY, resp);
    check_data("split_readback", 32'h0000_c3c3, data);
  endtask

  initial begin
    value_errs = 0;
    other_errs = 0;
    en_total   = 0;
    AXI_sreset = 1'b1;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    repeat (5) @(posedge AXI_aclk);
    #2;
    AXI_sreset = 1'b0;
    check_ready("reset_release", 1'b0);
    @(posedge AXI_aclk);
    #2;
    check_ready("reset_release", 1'b1);
    @(posedge AXI_aclk);
    #2;
    test_port_access();
    test_decerr();
    test_write_priority();
    test_backpressure();
    test_split_write();
    $display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: verification/drp_port_model.sv
`timescale 1ns/100ps

module drp_port_model #(
  parameter int IDX = 0
) (
  input  logic                     AXI_aclk,
  input  logic                     AXI_sreset,
  input  drp_bridge_pkg::drp_req_t req,
  output drp_bridge_pkg::drp_rsp_t rsp
);

  import drp_bridge_pkg::*;

  logic [DRP_DATA_W-1:0] mem [2**DRP_ADDR_W];
  integer                seed;
  int                    cnt;
  int                    lat;

  // Port index on top, register address below
  initial begin
    seed = 60464;
    for (int a = 0; a < 2**DRP_ADDR_W; a++) begin
      mem[a] = {IDX[3:0], 3'b000, a[8:0]};
    end
  end

  always @(posedge AXI_aclk or posedge AXI_sreset) begin
    if (AXI_sreset) begin
      rsp <= '0;
      cnt <= 0;
    end else begin
      rsp.rdy <= 1'b0;
      if (req.en) begin
        lat = 1 + ({$random(seed)} % 4);
        cnt <= lat;
        if (req.we) begin
          mem[req.addr] <= req.di;
        end else begin
          rsp.dout <= mem[req.addr];
        end
      end else if (cnt != 0) begin
        cnt <= cnt - 1;
        if (cnt == 1) begin
          rsp.rdy <= 1'b1;   // Single-cycle ready
        end
      end
    end
  end

endmodule
